//--- sources.f
+incdir+.
proc_pkg.sv
fetch.sv
decode.sv
hazard_unit.sv
execute.sv
memory.sv
proc.sv
proc_props.sv
proc_tb.sv

//--- Bender.yml
package:
  name: proc

export_include_dirs:
  - .

sources:
  - proc_pkg.sv
  - fetch.sv
  - decode.sv
  - hazard_unit.sv
  - execute.sv
  - memory.sv
  - proc.sv
  - target: test
    files:
      - proc_props.sv
      - proc_tb.sv

//--- proc_tb.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module proc_tb;

   localparam int CYCLE_LIMIT = 1000;
   localparam int PROG_WORDS  = 64;

   logic                        clk;
   logic                        reset;
   logic [`PROC_WORD_WIDTH-1:0] instrAddr;
   logic [`PROC_WORD_WIDTH-1:0] instr;
   logic                        memReq;
   logic                        memWrite;
   logic [`PROC_WORD_WIDTH-1:0] memAddr;
   logic [`PROC_WORD_WIDTH-1:0] memWriteData;
   logic                        memAck;
   logic [`PROC_WORD_WIDTH-1:0] memReadData;
   logic                        regWriteEn;
   logic [`PROC_REG_BITS-1:0]   regWriteAddr;
   logic [`PROC_WORD_WIDTH-1:0] regWriteData;
   logic                        halted;
   logic                        err;

   logic [15:0] prog [PROG_WORDS];
   logic [15:0] dataMem [64];
   logic [15:0] modelMem [64];
   logic [2:0]  expWAddr [$];
   logic [15:0] expWData [$];
   logic [15:0] expSAddr [$];
   logic [15:0] expSData [$];
   integer      seed;
   int          errors;
   int          retires;
   int          stores;
   int          cycles;

   proc UUT (.*);

   always #50 clk = !clk;

   // Instruction memory answers in the same cycle
   assign instr = (instrAddr < 2 * PROG_WORDS) ? prog[instrAddr[6:1]] : 16'h0800;

   function automatic logic [15:0] fillWord(input int a);
      return 16'(a * 16'h1357) ^ 16'hc0de;
   endfunction

   function automatic logic [15:0] randomWord(input int idx);
      proc_pkg::instrT w;
      logic [31:0]     r;
      int              k;
      r = $random(seed);
      w = 16'h0000;
      case (r[31:28] % 10)
         0, 1: begin
            w.rFmt.opcode = proc_pkg::OP_ALUR;
            w.rFmt.rs     = r[2:0];
            w.rFmt.rt     = r[5:3];
            w.rFmt.rd     = r[8:6];
            w.rFmt.funct  = proc_pkg::aluOpT'(r[10:9]);
         end
         2, 3, 4, 6, 7: begin
            case (r[31:28] % 10)
               2: w.iFmt.opcode = proc_pkg::OP_ADDI;
               3: w.iFmt.opcode = proc_pkg::OP_SUBI;
               4: w.iFmt.opcode = proc_pkg::OP_XORI;
               6: w.iFmt.opcode = proc_pkg::OP_LD;
               default: w.iFmt.opcode = proc_pkg::OP_ST;
            endcase
            w.iFmt.rs  = r[2:0];
            w.iFmt.rd  = r[5:3];
            w.iFmt.imm = r[15:11];
         end
         5: begin
            w.i8Fmt.opcode = proc_pkg::OP_LBI;
            w.i8Fmt.rs     = r[2:0];
            w.i8Fmt.imm    = r[18:11];
         end
         8: begin
            // Forward only, never past the final HALT
            k = r[22:21];
            if (k > PROG_WORDS - 2 - idx) begin
               k = PROG_WORDS - 2 - idx;
            end
            w.i8Fmt.opcode = r[20] ? proc_pkg::OP_BNEZ : proc_pkg::OP_BEQZ;
            w.i8Fmt.rs     = r[2:0];
            w.i8Fmt.imm    = 8'(2 * k);
         end
         default: w.rFmt.opcode = proc_pkg::OP_NOP;
      endcase
      return w;
   endfunction

   function automatic logic [15:0] sext5(input logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   function automatic logic [15:0] sext8(input logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   // ISA model, fills the expected write and store queues
   task automatic runModel();
      logic [15:0]     regs [8];
      logic [15:0]     a;
      logic [15:0]     addr;
      proc_pkg::instrT w;
      int              pc;
      bit              done;
      pc   = 0;
      done = 0;
      while (!done && pc < PROG_WORDS) begin
         w  = prog[pc];
         pc = pc + 1;
         a  = regs[w.rFmt.rs];
         addr = a + sext5(w.iFmt.imm);
         case (w.rFmt.opcode)
            proc_pkg::OP_ALUR: begin
               case (w.rFmt.funct)
                  proc_pkg::ALU_ADD: regs[w.rFmt.rd] = a + regs[w.rFmt.rt];
                  proc_pkg::ALU_SUB: regs[w.rFmt.rd] = a - regs[w.rFmt.rt];
                  proc_pkg::ALU_XOR: regs[w.rFmt.rd] = a ^ regs[w.rFmt.rt];
                  default:           regs[w.rFmt.rd] = a & ~regs[w.rFmt.rt];
               endcase
               expWAddr.push_back(w.rFmt.rd);
               expWData.push_back(regs[w.rFmt.rd]);
            end
            proc_pkg::OP_ADDI, proc_pkg::OP_SUBI, proc_pkg::OP_XORI, proc_pkg::OP_LD: begin
               case (w.iFmt.opcode)
                  proc_pkg::OP_ADDI: regs[w.iFmt.rd] = addr;
                  proc_pkg::OP_SUBI: regs[w.iFmt.rd] = a - sext5(w.iFmt.imm);
                  proc_pkg::OP_XORI: regs[w.iFmt.rd] = a ^ sext5(w.iFmt.imm);
                  default:           regs[w.iFmt.rd] = modelMem[addr[5:0]];
               endcase
               expWAddr.push_back(w.iFmt.rd);
               expWData.push_back(regs[w.iFmt.rd]);
            end
            proc_pkg::OP_ST: begin
               modelMem[addr[5:0]] = regs[w.iFmt.rd];
               expSAddr.push_back(addr);
               expSData.push_back(regs[w.iFmt.rd]);
            end
            proc_pkg::OP_LBI: begin
               regs[w.i8Fmt.rs] = sext8(w.i8Fmt.imm);
               expWAddr.push_back(w.i8Fmt.rs);
               expWData.push_back(regs[w.i8Fmt.rs]);
            end
            proc_pkg::OP_BEQZ, proc_pkg::OP_BNEZ: begin
               if ((a == 0) == (w.i8Fmt.opcode == proc_pkg::OP_BEQZ)) begin
                  pc = pc + int'(w.i8Fmt.imm) / 2;
               end
            end
            proc_pkg::OP_HALT: done = 1;
            // NOP and unknown words do nothing
            default: ;
         endcase
      end
   endtask

   task automatic expectLow(input string name, input logic value, input string when);
      if (value !== 1'b0) begin
         $display("[FAIL] %s %s: expected 0, got %h", name, when, value);
         errors++;
      end
   endtask

   task automatic checkQuiet(input string when);
      expectLow("memReq", memReq, when);
      expectLow("regWriteEn", regWriteEn, when);
      expectLow("halted", halted, when);
      expectLow("err", err, when);
      if (instrAddr !== `PROC_RESET_PC) begin
         $display("[FAIL] instrAddr: expected %h, got %h", `PROC_RESET_PC, instrAddr);
         errors++;
      end
   endtask

   task automatic applyReset();
      reset <= 1'b1;
      repeat (4) @(posedge clk);
      checkQuiet("during reset");
      reset <= 1'b0;
      @(posedge clk);
      checkQuiet("after reset");
      cycles = 0;
   endtask

   task automatic waitHaltAndCheck();
      while (!halted) begin
         @(posedge clk);
      end
      if (expWAddr.size() != 0 || expSAddr.size() != 0) begin
         $display("Halted with %0d register writes and %0d stores still expected",
                  expWAddr.size(), expSAddr.size());
         errors++;
      end
   endtask

   // Four-phase responder with random delays before each ack edge
   always begin
      int d;
      @(posedge clk);
      if (memReq && !reset) begin
         d = $random(seed) & 3;
         repeat (d) @(posedge clk);
         memAck      <= 1'b1;
         memReadData <= dataMem[memAddr[5:0]];
         if (memWrite) begin
            dataMem[memAddr[5:0]] = memWriteData;
            stores++;
            if (expSAddr.size() == 0) begin
               $display("Store to %h happened that the program never makes", memAddr);
               errors++;
            end else begin
               if (memAddr !== expSAddr[0]) begin
                  $display("[FAIL] memAddr: expected %h, got %h", expSAddr[0], memAddr);
                  errors++;
               end
               if (memWriteData !== expSData[0]) begin
                  $display("[FAIL] memWriteData: expected %h, got %h",
                           expSData[0], memWriteData);
                  errors++;
               end
               void'(expSAddr.pop_front());
               void'(expSData.pop_front());
            end
         end
         @(posedge clk);
         while (memReq) begin
            @(posedge clk);
         end
         d = $random(seed) & 3;
         repeat (d) @(posedge clk);
         memAck <= 1'b0;
      end
   end

   // Retire stream against the model
   always @(posedge clk) begin
      if (regWriteEn && !reset) begin
         retires++;
         if (expWAddr.size() == 0) begin
            $display("Register %0d written although no write was expected", regWriteAddr);
            errors++;
         end else begin
            if (regWriteAddr !== expWAddr[0]) begin
               $display("[FAIL] regWriteAddr: expected %h, got %h", expWAddr[0], regWriteAddr);
               errors++;
            end
            if (regWriteData !== expWData[0]) begin
               $display("[FAIL] regWriteData: expected %h, got %h", expWData[0], regWriteData);
               errors++;
            end
            void'(expWAddr.pop_front());
            void'(expWData.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the processor never halted", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      memAck      = 1'b0;
      memReadData = '0;
      seed        = 32'hdd52_f22e;
      errors      = 0;
      retires     = 0;
      stores      = 0;
      cycles      = 0;
      for (int i = 0; i < 64; i++) begin
         dataMem[i]  = fillWord(i);
         modelMem[i] = fillWord(i);
      end
      // Register file has no reset, so load every register first
      for (int i = 0; i < 8; i++) begin
         prog[i] = {proc_pkg::OP_LBI, 3'(i), 8'($random(seed))};
      end
      for (int i = 8; i < PROG_WORDS - 1; i++) begin
         prog[i] = randomWord(i);
      end
      prog[PROG_WORDS-1] = 16'h0000;
      runModel();
      applyReset();
      waitHaltAndCheck();
      repeat (20) begin
         @(posedge clk);
         expectLow("regWriteEn", regWriteEn, "after halt");
         expectLow("memReq", memReq, "after halt");
      end
      expectLow("err", err, "after halt");

      // Directed run with an unknown opcode in the middle
      for (int i = 0; i < PROG_WORDS; i++) begin
         prog[i] = {proc_pkg::OP_NOP, 11'h000};
      end
      prog[0] = {proc_pkg::OP_LBI, 3'd1, 8'd5};
      prog[1] = {proc_pkg::OP_ADDI, 3'd1, 3'd2, 5'd3};
      prog[2] = {5'b00010, 11'h123};
      prog[3] = 16'h0000;
      runModel();
      applyReset();
      waitHaltAndCheck();
      if (err !== 1'b1) begin
         $display("[FAIL] err: expected %h, got %h", 1'b1, err);
         errors++;
      end

      $display("Errors: %0d, assertion failures: %0d, retires: %0d, stores: %0d",
               errors, UUT.props.failures, retires, stores);
      if (errors == 0 && UUT.props.failures == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- proc_props.sv
`timescale 1ns/1ps

module proc_props (
   input logic clk,
   input logic reset,
   input logic memReq,
   input logic memAck,
   input logic regWriteEn,
   input logic halted
);

   int failures = 0;

   // Request stays up until the responder acks
   reqHeld: assert property (@(posedge clk) disable iff (reset)
      memReq && !memAck |=> memReq)
      else begin
         $error("memReq dropped before memAck");
         failures++;
      end

   reqRiseAckLow: assert property (@(posedge clk) disable iff (reset)
      $rose(memReq) |-> !memAck)
      else begin
         $error("memReq rose while memAck high");
         failures++;
      end

   reqLowAfterReset: assert property (@(posedge clk) reset |=> !memReq)
      else begin
         $error("memReq high after reset");
         failures++;
      end

   noRetireHalted: assert property (@(posedge clk) disable iff (reset)
      !(regWriteEn && halted))
      else begin
         $error("regWriteEn high while halted");
         failures++;
      end

endmodule

bind proc proc_props props (
   .clk(clk), .reset(reset), .memReq(memReq), .memAck(memAck),
   .regWriteEn(regWriteEn), .halted(halted)
);

//--- proc.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module proc (
   input  logic                        clk,
   input  logic                        reset,
   output logic [`PROC_WORD_WIDTH-1:0] instrAddr,
   input  logic [`PROC_WORD_WIDTH-1:0] instr,
   output logic                        memReq,
   output logic                        memWrite,
   output logic [`PROC_WORD_WIDTH-1:0] memAddr,
   output logic [`PROC_WORD_WIDTH-1:0] memWriteData,
   input  logic                        memAck,
   input  logic [`PROC_WORD_WIDTH-1:0] memReadData,
   output logic                        regWriteEn,
   output logic [`PROC_REG_BITS-1:0]   regWriteAddr,
   output logic [`PROC_WORD_WIDTH-1:0] regWriteData,
   output logic                        halted,
   output logic                        err
);

   logic                        stall;
   logic                        memStall;
   logic                        halt;
   logic                        redirect;
   logic [`PROC_WORD_WIDTH-1:0] redirectPc;
   logic [`PROC_WORD_WIDTH-1:0] ifidInstr;
   logic [`PROC_WORD_WIDTH-1:0] ifidPcInc;
   logic                        ifidValid;
   proc_pkg::instrT             idWord;
   logic                        idUsesRt;
   logic                        idIsBranch;
   logic                        illegal;
   logic                        idexValid;
   proc_pkg::opcodeT            idexOp;
   proc_pkg::aluOpT             idexAluOp;
   logic [`PROC_REG_BITS-1:0]   idexRs;
   logic [`PROC_REG_BITS-1:0]   idexRt;
   logic [`PROC_REG_BITS-1:0]   idexRd;
   logic [`PROC_WORD_WIDTH-1:0] idexA;
   logic [`PROC_WORD_WIDTH-1:0] idexB;
   logic [`PROC_WORD_WIDTH-1:0] idexImm;
   logic                        idexRegWrite;
   logic                        exIsLoad;
   logic                        exmemValid;
   proc_pkg::opcodeT            exmemOp;
   logic [`PROC_REG_BITS-1:0]   exmemRd;
   logic [`PROC_WORD_WIDTH-1:0] exmemResult;
   logic [`PROC_WORD_WIDTH-1:0] exmemStoreData;
   logic                        exmemRegWrite;
   logic                        memIsLoad;
   logic                        fwdDecode;
   proc_pkg::fwdSelT            fwdExA;
   proc_pkg::fwdSelT            fwdExB;
   logic                        wbEn;
   logic [`PROC_REG_BITS-1:0]   wbAddr;
   logic [`PROC_WORD_WIDTH-1:0] wbData;
   logic                        wbHalt;

   // Hazard view of the word sitting in decode
   assign idWord     = ifidInstr;
   assign idUsesRt   = ifidValid && (idWord.rFmt.opcode == proc_pkg::OP_ALUR ||
                                     idWord.rFmt.opcode == proc_pkg::OP_ST);
   assign idIsBranch = ifidValid && (idWord.rFmt.opcode == proc_pkg::OP_BEQZ ||
                                     idWord.rFmt.opcode == proc_pkg::OP_BNEZ);
   assign exIsLoad   = idexValid && idexOp == proc_pkg::OP_LD;
   assign memIsLoad  = exmemValid && exmemOp == proc_pkg::OP_LD;

   fetch fetchStage (
      .clk(clk), .reset(reset), .stall(stall), .memStall(memStall), .halt(halt),
      .redirect(redirect), .redirectPc(redirectPc), .instrAddr(instrAddr), .instr(instr),
      .ifidInstr(ifidInstr), .ifidPcInc(ifidPcInc), .ifidValid(ifidValid)
   );

   decode decodeStage (
      .clk(clk), .reset(reset), .stall(stall), .memStall(memStall),
      .ifidInstr(ifidInstr), .ifidPcInc(ifidPcInc), .ifidValid(ifidValid),
      .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
      .exRd(idexRd), .exRegWrite(idexRegWrite),
      .memRd(exmemRd), .memRegWrite(exmemRegWrite), .memResult(exmemResult),
      .fwdDecode(fwdDecode),
      .redirect(redirect), .redirectPc(redirectPc), .halt(halt), .illegal(illegal),
      .idexValid(idexValid), .idexOp(idexOp), .idexAluOp(idexAluOp),
      .idexRs(idexRs), .idexRt(idexRt), .idexRd(idexRd),
      .idexA(idexA), .idexB(idexB), .idexImm(idexImm), .idexRegWrite(idexRegWrite)
   );

   hazard_unit hazards (
      .idRs(idWord.rFmt.rs), .idRt(idWord.rFmt.rt), .idUsesRt(idUsesRt),
      .idIsBranch(idIsBranch),
      .exRd(idexRd), .exRegWrite(idexRegWrite), .exIsLoad(exIsLoad),
      .memRd(exmemRd), .memRegWrite(exmemRegWrite), .memIsLoad(memIsLoad),
      .wbRd(wbAddr), .wbRegWrite(wbEn), .exRs(idexRs), .exRt(idexRt),
      .stall(stall), .fwdDecode(fwdDecode), .fwdExA(fwdExA), .fwdExB(fwdExB)
   );

   execute executeStage (
      .clk(clk), .reset(reset), .memStall(memStall),
      .idexValid(idexValid), .idexOp(idexOp), .idexAluOp(idexAluOp), .idexRd(idexRd),
      .idexA(idexA), .idexB(idexB), .idexImm(idexImm), .idexRegWrite(idexRegWrite),
      .fwdExA(fwdExA), .fwdExB(fwdExB), .memResult(exmemResult), .wbData(wbData),
      .exmemValid(exmemValid), .exmemOp(exmemOp), .exmemRd(exmemRd),
      .exmemResult(exmemResult), .exmemStoreData(exmemStoreData),
      .exmemRegWrite(exmemRegWrite)
   );

   memory memoryStage (
      .clk(clk), .reset(reset),
      .exmemValid(exmemValid), .exmemOp(exmemOp), .exmemRd(exmemRd),
      .exmemResult(exmemResult), .exmemStoreData(exmemStoreData),
      .exmemRegWrite(exmemRegWrite),
      .memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
      .memWriteData(memWriteData), .memAck(memAck), .memReadData(memReadData),
      .memStall(memStall), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData), .wbHalt(wbHalt)
   );

   assign regWriteEn   = wbEn;
   assign regWriteAddr = wbAddr;
   assign regWriteData = wbData;
   assign halted       = wbHalt;
   assign err          = illegal;

endmodule

//--- memory.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module memory (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        exmemValid,
   input  proc_pkg::opcodeT            exmemOp,
   input  logic [`PROC_REG_BITS-1:0]   exmemRd,
   input  logic [`PROC_WORD_WIDTH-1:0] exmemResult,
   input  logic [`PROC_WORD_WIDTH-1:0] exmemStoreData,
   input  logic                        exmemRegWrite,
   output logic                        memReq,
   output logic                        memWrite,
   output logic [`PROC_WORD_WIDTH-1:0] memAddr,
   output logic [`PROC_WORD_WIDTH-1:0] memWriteData,
   input  logic                        memAck,
   input  logic [`PROC_WORD_WIDTH-1:0] memReadData,
   output logic                        memStall,
   output logic                        wbEn,
   output logic [`PROC_REG_BITS-1:0]   wbAddr,
   output logic [`PROC_WORD_WIDTH-1:0] wbData,
   output logic                        wbHalt
);

   typedef enum logic [1:0] {IDLE, WAIT_ACK, WAIT_RELEASE} stateT;

   stateT                       state;
   logic                        isLoad;
   logic                        isMem;
   logic                        done;
   logic                        wbRegWrite;
   logic [`PROC_WORD_WIDTH-1:0] readData;

   assign isLoad = exmemValid && exmemOp == proc_pkg::OP_LD;
   assign isMem  = isLoad || (exmemValid && exmemOp == proc_pkg::OP_ST);

   // Access ends once ack has fallen
   assign done     = state == WAIT_RELEASE && !memAck;
   assign memStall = isMem && !done;

   assign memReq       = state == WAIT_ACK;
   assign memWrite     = isMem && exmemOp == proc_pkg::OP_ST;
   assign memAddr      = exmemResult;
   assign memWriteData = exmemStoreData;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (isMem && !memAck) begin
                  state <= WAIT_ACK;
               end
            end
            WAIT_ACK: begin
               if (memAck) begin
                  state <= WAIT_RELEASE;
               end
            end
            default: begin
               if (!memAck) begin
                  state <= IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == WAIT_ACK && memAck) begin
         readData <= memReadData;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wbRegWrite <= 1'b0;
         wbHalt     <= 1'b0;
      end else if (!memStall) begin
         wbRegWrite <= exmemValid && exmemRegWrite;
         if (exmemValid && exmemOp == proc_pkg::OP_HALT) begin
            wbHalt <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!memStall) begin
         wbAddr <= exmemRd;
         wbData <= isLoad ? readData : exmemResult;
      end
   end

   // One retire pulse, even while a later access holds the pipe
   assign wbEn = wbRegWrite && !memStall;

endmodule

//--- execute.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module execute (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        memStall,
   input  logic                        idexValid,
   input  proc_pkg::opcodeT            idexOp,
   input  proc_pkg::aluOpT             idexAluOp,
   input  logic [`PROC_REG_BITS-1:0]   idexRd,
   input  logic [`PROC_WORD_WIDTH-1:0] idexA,
   input  logic [`PROC_WORD_WIDTH-1:0] idexB,
   input  logic [`PROC_WORD_WIDTH-1:0] idexImm,
   input  logic                        idexRegWrite,
   input  proc_pkg::fwdSelT            fwdExA,
   input  proc_pkg::fwdSelT            fwdExB,
   input  logic [`PROC_WORD_WIDTH-1:0] memResult,
   input  logic [`PROC_WORD_WIDTH-1:0] wbData,
   output logic                        exmemValid,
   output proc_pkg::opcodeT            exmemOp,
   output logic [`PROC_REG_BITS-1:0]   exmemRd,
   output logic [`PROC_WORD_WIDTH-1:0] exmemResult,
   output logic [`PROC_WORD_WIDTH-1:0] exmemStoreData,
   output logic                        exmemRegWrite
);

   logic [`PROC_WORD_WIDTH-1:0] opA;
   logic [`PROC_WORD_WIDTH-1:0] opB;
   logic [`PROC_WORD_WIDTH-1:0] aluB;
   logic [`PROC_WORD_WIDTH-1:0] result;

   always_comb begin
      case (fwdExA)
         proc_pkg::FWD_MEM: opA = memResult;
         proc_pkg::FWD_WB:  opA = wbData;
         default:           opA = idexA;
      endcase
      case (fwdExB)
         proc_pkg::FWD_MEM: opB = memResult;
         proc_pkg::FWD_WB:  opB = wbData;
         default:           opB = idexB;
      endcase
      // Only R-format takes a register as second ALU input
      aluB = (idexOp == proc_pkg::OP_ALUR) ? opB : idexImm;
      case (idexAluOp)
         proc_pkg::ALU_ADD: result = opA + aluB;
         proc_pkg::ALU_SUB: result = opA - aluB;
         proc_pkg::ALU_XOR: result = opA ^ aluB;
         default:           result = opA & ~aluB;
      endcase
      if (idexOp == proc_pkg::OP_LBI) begin
         result = idexImm;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         exmemValid    <= 1'b0;
         exmemRegWrite <= 1'b0;
      end else if (!memStall) begin
         exmemValid    <= idexValid;
         exmemRegWrite <= idexRegWrite;
      end
   end

   always_ff @(posedge clk) begin
      if (!memStall) begin
         exmemOp        <= idexOp;
         exmemRd        <= idexRd;
         exmemResult    <= result;
         exmemStoreData <= opB;
      end
   end

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module hazard_unit (
   input  logic [`PROC_REG_BITS-1:0] idRs,
   input  logic [`PROC_REG_BITS-1:0] idRt,
   input  logic                      idUsesRt,
   input  logic                      idIsBranch,
   input  logic [`PROC_REG_BITS-1:0] exRd,
   input  logic                      exRegWrite,
   input  logic                      exIsLoad,
   input  logic [`PROC_REG_BITS-1:0] memRd,
   input  logic                      memRegWrite,
   input  logic                      memIsLoad,
   input  logic [`PROC_REG_BITS-1:0] wbRd,
   input  logic                      wbRegWrite,
   input  logic [`PROC_REG_BITS-1:0] exRs,
   input  logic [`PROC_REG_BITS-1:0] exRt,
   output logic                      stall,
   output logic                      fwdDecode,
   output proc_pkg::fwdSelT          fwdExA,
   output proc_pkg::fwdSelT          fwdExB
);

   logic exHitsRs;
   logic exHitsRt;
   logic memHitsRs;

   assign exHitsRs  = exRegWrite && exRd == idRs;
   assign exHitsRt  = exRegWrite && idUsesRt && exRd == idRt;
   assign memHitsRs = memRegWrite && memRd == idRs;

   // Load data only exists after the memory stage
   assign stall = (exIsLoad && (exHitsRs || exHitsRt)) ||
                  (idIsBranch && (exHitsRs || (memHitsRs && memIsLoad)));

   assign fwdDecode = memHitsRs && !memIsLoad;

   function automatic proc_pkg::fwdSelT pickSource(input logic [`PROC_REG_BITS-1:0] src);
      if (memRegWrite && !memIsLoad && memRd == src) begin
         return proc_pkg::FWD_MEM;
      end
      if (wbRegWrite && wbRd == src) begin
         return proc_pkg::FWD_WB;
      end
      return proc_pkg::FWD_REG;
   endfunction

   always_comb begin
      fwdExA = pickSource(exRs);
      fwdExB = pickSource(exRt);
   end

endmodule

//--- decode.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module decode (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        stall,
   input  logic                        memStall,
   input  logic [`PROC_WORD_WIDTH-1:0] ifidInstr,
   input  logic [`PROC_WORD_WIDTH-1:0] ifidPcInc,
   input  logic                        ifidValid,
   input  logic                        wbEn,
   input  logic [`PROC_REG_BITS-1:0]   wbAddr,
   input  logic [`PROC_WORD_WIDTH-1:0] wbData,
   input  logic [`PROC_REG_BITS-1:0]   exRd,
   input  logic                        exRegWrite,
   input  logic [`PROC_REG_BITS-1:0]   memRd,
   input  logic                        memRegWrite,
   input  logic [`PROC_WORD_WIDTH-1:0] memResult,
   input  logic                        fwdDecode,
   output logic                        redirect,
   output logic [`PROC_WORD_WIDTH-1:0] redirectPc,
   output logic                        halt,
   output logic                        illegal,
   output logic                        idexValid,
   output proc_pkg::opcodeT            idexOp,
   output proc_pkg::aluOpT             idexAluOp,
   output logic [`PROC_REG_BITS-1:0]   idexRs,
   output logic [`PROC_REG_BITS-1:0]   idexRt,
   output logic [`PROC_REG_BITS-1:0]   idexRd,
   output logic [`PROC_WORD_WIDTH-1:0] idexA,
   output logic [`PROC_WORD_WIDTH-1:0] idexB,
   output logic [`PROC_WORD_WIDTH-1:0] idexImm,
   output logic                        idexRegWrite
);

   proc_pkg::instrT             ir;
   proc_pkg::opcodeT            op;
   proc_pkg::aluOpT             aluOp;
   logic [`PROC_WORD_WIDTH-1:0] regs [`PROC_REG_COUNT];
   logic [`PROC_REG_BITS-1:0]   rs;
   logic [`PROC_REG_BITS-1:0]   rt;
   logic [`PROC_REG_BITS-1:0]   rd;
   logic [`PROC_WORD_WIDTH-1:0] imm;
   logic [`PROC_WORD_WIDTH-1:0] rsVal;
   logic [`PROC_WORD_WIDTH-1:0] rtVal;
   logic                        regWrite;
   logic                        isBranch;
   logic                        isHalt;
   logic                        unknown;
   logic                        branchReady;
   logic                        taken;
   logic                        issue;

   assign ir = ifidInstr;
   assign op = ir.rFmt.opcode;
   assign rs = ir.rFmt.rs;

   always_comb begin
      aluOp    = proc_pkg::ALU_ADD;
      rt       = ir.rFmt.rt;
      rd       = ir.iFmt.rd;
      imm      = {{(`PROC_WORD_WIDTH-5){ir.iFmt.imm[4]}}, ir.iFmt.imm};
      regWrite = 1'b0;
      isBranch = 1'b0;
      isHalt   = 1'b0;
      unknown  = 1'b0;
      case (op)
         proc_pkg::OP_ALUR: begin
            aluOp    = ir.rFmt.funct;
            rd       = ir.rFmt.rd;
            regWrite = 1'b1;
         end
         proc_pkg::OP_ADDI, proc_pkg::OP_LD: begin
            regWrite = 1'b1;
         end
         proc_pkg::OP_SUBI: begin
            aluOp    = proc_pkg::ALU_SUB;
            regWrite = 1'b1;
         end
         proc_pkg::OP_XORI: begin
            aluOp    = proc_pkg::ALU_XOR;
            regWrite = 1'b1;
         end
         proc_pkg::OP_LBI: begin
            rd       = ir.i8Fmt.rs;
            imm      = {{(`PROC_WORD_WIDTH-8){ir.i8Fmt.imm[7]}}, ir.i8Fmt.imm};
            regWrite = 1'b1;
         end
         proc_pkg::OP_BEQZ, proc_pkg::OP_BNEZ: begin
            imm      = {{(`PROC_WORD_WIDTH-8){ir.i8Fmt.imm[7]}}, ir.i8Fmt.imm};
            isBranch = 1'b1;
         end
         proc_pkg::OP_HALT: begin
            isHalt = 1'b1;
         end
         // Store data register already sits in the rt bits
         proc_pkg::OP_ST, proc_pkg::OP_NOP: begin
         end
         default: begin
            unknown = 1'b1;
         end
      endcase
   end

   // Writeback bypass, rs may also come straight from memory stage
   assign rsVal = fwdDecode ? memResult :
                  (wbEn && wbAddr == rs) ? wbData : regs[rs];
   assign rtVal = (wbEn && wbAddr == rt) ? wbData : regs[rt];

   // Operand still in flight from execute, or a load in memory
   assign branchReady = !(exRegWrite && exRd == rs) &&
                        !(memRegWrite && memRd == rs && !fwdDecode);

   assign issue      = ifidValid && !stall && !memStall;
   assign taken      = (op == proc_pkg::OP_BEQZ) ? (rsVal == '0) : (rsVal != '0);
   assign redirect   = issue && isBranch && branchReady && taken;
   assign redirectPc = ifidPcInc + imm;
   assign halt       = issue && isHalt;

   always_ff @(posedge clk) begin
      if (wbEn) begin
         regs[wbAddr] <= wbData;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         illegal <= 1'b0;
      end else if (issue && unknown) begin
         illegal <= 1'b1;
      end
   end

   // Stall or unknown opcode becomes a bubble
   always_ff @(posedge clk) begin
      if (reset) begin
         idexValid    <= 1'b0;
         idexRegWrite <= 1'b0;
      end else if (!memStall) begin
         idexValid    <= issue && !unknown;
         idexRegWrite <= issue && !unknown && regWrite;
      end
   end

   always_ff @(posedge clk) begin
      if (!memStall) begin
         idexOp    <= op;
         idexAluOp <= aluOp;
         idexRs    <= rs;
         idexRt    <= rt;
         idexRd    <= rd;
         idexA     <= rsVal;
         idexB     <= rtVal;
         idexImm   <= imm;
      end
   end

endmodule

//--- fetch.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module fetch (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        stall,
   input  logic                        memStall,
   input  logic                        halt,
   input  logic                        redirect,
   input  logic [`PROC_WORD_WIDTH-1:0] redirectPc,
   output logic [`PROC_WORD_WIDTH-1:0] instrAddr,
   input  logic [`PROC_WORD_WIDTH-1:0] instr,
   output logic [`PROC_WORD_WIDTH-1:0] ifidInstr,
   output logic [`PROC_WORD_WIDTH-1:0] ifidPcInc,
   output logic                        ifidValid
);

   logic [`PROC_WORD_WIDTH-1:0] pc;
   logic [`PROC_WORD_WIDTH-1:0] pcInc;
   logic                        stopped;
   logic                        advance;

   assign instrAddr = pc;
   assign pcInc     = pc + (`PROC_WORD_WIDTH)'(2);
   assign advance   = !memStall && !stall && !redirect && !halt && !stopped;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc        <= `PROC_RESET_PC;
         ifidValid <= 1'b0;
         stopped   <= 1'b0;
      end else if (!memStall) begin
         if (redirect) begin
            pc <= redirectPc;
         end else if (advance) begin
            pc <= pcInc;
         end
         // Taken branch or halt leaves a bubble behind
         if (!stall) begin
            ifidValid <= advance;
         end
         if (halt) begin
            stopped <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         ifidInstr <= instr;
         ifidPcInc <= pcInc;
      end
   end

endmodule

//--- proc_pkg.sv
package proc_pkg;

   // Opcode is the top five bits of every word
   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_ADDI = 5'b01000,
      OP_SUBI = 5'b01001,
      OP_XORI = 5'b01010,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_LBI  = 5'b11000,
      OP_ALUR = 5'b11011
   } opcodeT;

   // Also the funct coding of R-format words
   // SUB and SUBI compute rs minus the second operand
   typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN} aluOpT;

   // Operand source for the execute stage
   typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwdSelT;

   typedef union packed {
      struct packed {
         opcodeT     opcode;
         logic [2:0] rs;
         logic [2:0] rt;
         logic [2:0] rd;
         aluOpT      funct;
      } rFmt;
      // ST stores the register named in rd
      struct packed {
         opcodeT     opcode;
         logic [2:0] rs;
         logic [2:0] rd;
         logic [4:0] imm;
      } iFmt;
      // LBI writes rs, branches test rs
      struct packed {
         opcodeT     opcode;
         logic [2:0] rs;
         logic [7:0] imm;
      } i8Fmt;
   } instrT;

endpackage

//--- proc_settings.svh
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// Data and instruction word
`define PROC_WORD_WIDTH 16

// Register file size and index width
`define PROC_REG_COUNT 8
`define PROC_REG_BITS 3

// First address fetched out of reset
`define PROC_RESET_PC 16'h0000

`endif
